/* hdl/arb_defines.svh */
/*
  Shared sizing macros for the command channel arbiters
  Port count, opcode width and packet field widths
*/
`ifndef ARB_DEFINES_SVH
`define ARB_DEFINES_SVH

// ---------------------------------------------------------------------------
// Engine count
// ---------------------------------------------------------------------------
// Number of engines sharing the command channel
`define ARB_NUM_PORTS 4

// ---------------------------------------------------------------------------
// Packet field widths
// ---------------------------------------------------------------------------
// Opcode field, wide enough for the four packet kinds
`define ARB_OPCODE_WIDTH 2
// Source or destination engine id
`define ARB_SRC_WIDTH 2
// Payload word
`define ARB_DATA_WIDTH 16

`endif

/* hdl/arb_pkg.sv */
/*
  Command channel types
  Opcode encoding and the packet word carried by both arbiters
*/
`include "arb_defines.svh"

package arb_pkg;

  // -------------------------------------------------------------------------
  // Opcodes
  // -------------------------------------------------------------------------
  // Zero opcode marks an empty slot, so an all-zero word is "no packet"
  typedef enum logic [`ARB_OPCODE_WIDTH-1:0] {
    op_none  = 2'd0,
    op_read  = 2'd1,
    op_write = 2'd2,
    op_resp  = 2'd3
  } opcode_t;

  // -------------------------------------------------------------------------
  // Packet word
  // -------------------------------------------------------------------------
  // Opcode in the top bits, then engine id, then payload (20 bits total)
  typedef struct packed {
    opcode_t                   opcode;
    logic [`ARB_SRC_WIDTH-1:0] src;
    // Payload, meaning depends on opcode
    logic [`ARB_DATA_WIDTH-1:0] data;
  } packet_t;

endpackage

/* hdl/rr_grant_core.sv */
/*
  Round-robin grant core
  One-hot grant to the first raised request at or after a rotating pointer,
  the winner drops to lowest priority on the next cycle
*/
`timescale 1ns/1ps
`include "arb_defines.svh"

module rr_grant_core #(
  parameter int NUM_REQUESTS = `ARB_NUM_PORTS
) (
  input  logic                    clock,
  input  logic                    rstn,
  input  logic [NUM_REQUESTS-1:0] reqs,
  output logic [NUM_REQUESTS-1:0] grants
);

  generate
    if (NUM_REQUESTS > 1) begin : g_rotate
      localparam int PTR_W = $clog2(NUM_REQUESTS);

      // Highest-priority engine for the current cycle
      logic [PTR_W-1:0] ptr;
      logic [PTR_W-1:0] next_ptr;
      logic             any_grant;

      // Scan from the pointer upward, wrapping past the last engine
      always_comb begin
        int idx;
        grants    = '0;
        next_ptr  = ptr;
        any_grant = 1'b0;
        for (int k = 0; k < NUM_REQUESTS; k++) begin
          idx = (int'(ptr) + k) % NUM_REQUESTS;
          if (!any_grant && reqs[idx]) begin
            grants[idx] = 1'b1;
            any_grant   = 1'b1;
            // Winner moves to the back of the line
            next_ptr    = (idx == NUM_REQUESTS - 1) ? '0 : PTR_W'(idx + 1);
          end
        end
      end

      // Pointer only moves when someone actually won
      always_ff @(posedge clock or negedge rstn) begin
        if (!rstn) begin
          ptr <= '0;
        end else if (any_grant) begin
          ptr <= next_ptr;
        end
      end
    end else begin : g_single
      // Lone engine, nothing to rotate; grant trails the request by a cycle
      always_ff @(posedge clock or negedge rstn) begin
        if (!rstn) begin
          grants <= '0;
        end else begin
          grants <= reqs;
        end
      end
    end
  endgenerate

endmodule

/* hdl/rr_arbiter_n_to_1.sv */
/*
  N-to-1 round-robin command arbiter
  Turns grants into registered ready strobes and forwards the submitted
  packet of the winning engine onto one shared output
*/
`timescale 1ns/1ps
`include "arb_defines.svh"

module rr_arbiter_n_to_1 #(
  parameter int NUM_REQUESTS = `ARB_NUM_PORTS
) (
  input  logic                    clock,
  input  logic                    rstn,
  input  logic                    enabled,
  input  arb_pkg::packet_t        buffer_in [0:NUM_REQUESTS-1],
  input  logic [NUM_REQUESTS-1:0] submit,
  input  logic [NUM_REQUESTS-1:0] requests,
  output arb_pkg::packet_t        arbiter_out,
  output logic [NUM_REQUESTS-1:0] ready
);
  import arb_pkg::*;

  logic [NUM_REQUESTS-1:0] grant;
  // Enable delayed one cycle, lines up with the registered grant
  logic                    enabled_internal;
  // Packet picked from the submitting engines this cycle
  packet_t                 submitted;

  rr_grant_core #(
    .NUM_REQUESTS(NUM_REQUESTS)
  ) u_grant (
    .clock (clock),
    .rstn  (rstn),
    .reqs  (requests),
    .grants(grant)
  );

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      enabled_internal <= 1'b0;
    end else begin
      enabled_internal <= enabled;
    end
  end

  // ---------------------------------------------------------------------------
  // Submit mux
  // ---------------------------------------------------------------------------
  // Only the ready engine should submit, so at most one bit is expected;
  // highest index wins if several collide
  always_comb begin
    submitted = '0;
    for (int i = 0; i < NUM_REQUESTS; i++) begin
      if (submit[i]) begin
        submitted = buffer_in[i];
      end
    end
  end

  // Output stage freezes while the internal enable is low
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      ready       <= '0;
      arbiter_out <= '0;
    end else if (enabled_internal) begin
      ready       <= grant;
      arbiter_out <= submitted;
    end
  end

endmodule

/* hdl/rr_arbiter_1_to_n.sv */
/*
  1-to-N round-robin response arbiter
  Latches the grant under enable and steers the response word to the
  latched engine one cycle later, zeroing every other output
*/
`timescale 1ns/1ps
`include "arb_defines.svh"

module rr_arbiter_1_to_n #(
  parameter int NUM_REQUESTS = `ARB_NUM_PORTS
) (
  input  logic                    clock,
  input  logic                    rstn,
  input  logic                    enabled,
  input  arb_pkg::packet_t        buffer_in,
  input  logic [NUM_REQUESTS-1:0] requests,
  output arb_pkg::packet_t        arbiter_out [0:NUM_REQUESTS-1],
  output logic [NUM_REQUESTS-1:0] ready
);
  import arb_pkg::*;

  logic [NUM_REQUESTS-1:0] grant;
  // Winner held across cycles where enable is low
  logic [NUM_REQUESTS-1:0] grant_latched;
  // Demuxed response before the output register
  packet_t                 steer [0:NUM_REQUESTS-1];

  rr_grant_core #(
    .NUM_REQUESTS(NUM_REQUESTS)
  ) u_grant (
    .clock (clock),
    .rstn  (rstn),
    .reqs  (requests),
    .grants(grant)
  );

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      grant_latched <= '0;
    end else if (enabled) begin
      grant_latched <= grant;
    end
  end

  // ---------------------------------------------------------------------------
  // Response demux
  // ---------------------------------------------------------------------------
  always_comb begin
    for (int i = 0; i < NUM_REQUESTS; i++) begin
      steer[i] = grant_latched[i] ? buffer_in : '0;
    end
  end

  // Payload register, every output rewritten each cycle
  always_ff @(posedge clock) begin
    arbiter_out <= steer;
  end

  // Ready drops at once when the path is disabled
  assign ready = grant_latched & {NUM_REQUESTS{enabled}};

endmodule

/* hdl/cmd_channel_top.sv */
/*
  Shared command channel
  Command arbiter merges engine packets onto one output, response arbiter
  hands the single response stream back to the engines
*/
`timescale 1ns/1ps
`include "arb_defines.svh"

module cmd_channel_top (
  input  logic                      clock,
  input  logic                      rstn,
  // Command path, engines to shared channel
  input  logic                      cmd_enable,
  input  logic [`ARB_NUM_PORTS-1:0] cmd_req,
  input  logic [`ARB_NUM_PORTS-1:0] cmd_submit,
  input  arb_pkg::packet_t          cmd_in [0:`ARB_NUM_PORTS-1],
  output arb_pkg::packet_t          cmd_out,
  output logic [`ARB_NUM_PORTS-1:0] cmd_ready,
  // Response path, shared channel back to engines
  input  logic                      resp_enable,
  input  logic [`ARB_NUM_PORTS-1:0] resp_req,
  input  arb_pkg::packet_t          resp_in,
  output arb_pkg::packet_t          resp_out [0:`ARB_NUM_PORTS-1],
  output logic [`ARB_NUM_PORTS-1:0] resp_ready
);

  // ---------------------------------------------------------------------------
  // Command path
  // ---------------------------------------------------------------------------
  rr_arbiter_n_to_1 #(
    .NUM_REQUESTS(`ARB_NUM_PORTS)
  ) cmd_arb (
    .clock      (clock),
    .rstn       (rstn),
    .enabled    (cmd_enable),
    .buffer_in  (cmd_in),
    .submit     (cmd_submit),
    .requests   (cmd_req),
    .arbiter_out(cmd_out),
    .ready      (cmd_ready)
  );

  // ---------------------------------------------------------------------------
  // Response path
  // ---------------------------------------------------------------------------
  // Independent of the command side, own pointer and own enable
  rr_arbiter_1_to_n #(
    .NUM_REQUESTS(`ARB_NUM_PORTS)
  ) resp_arb (
    .clock      (clock),
    .rstn       (rstn),
    .enabled    (resp_enable),
    .buffer_in  (resp_in),
    .requests   (resp_req),
    .arbiter_out(resp_out),
    .ready      (resp_ready)
  );

endmodule

/* testbench/tb_asserts.sv */
/*
  Concurrent checks for the round-robin arbiters
  Grant shape in the grant core and ready behavior in the response arbiter
*/
`timescale 1ns/1ps

module arb_asserts #(
  parameter int N         = 4,
  parameter bit CORE_VIEW = 1'b1
) (
  input logic         clock,
  input logic         rstn,
  input logic [N-1:0] reqs,
  input logic [N-1:0] grants,
  input logic [N-1:0] ready
);

  // Failure tallies per check kind
  int fail_onehot   = 0;
  int fail_spurious = 0;
  int fail_missing  = 0;
  int fail_reset    = 0;
  int fail_total;

  assign fail_total = fail_onehot + fail_spurious + fail_missing + fail_reset;

  // --------------------------------------------------------------------------
  // Grant core view
  // --------------------------------------------------------------------------
  generate
    if (CORE_VIEW && N > 1) begin : g_core
      // At most one winner per cycle
      a_onehot : assert property (@(posedge clock) disable iff (!rstn) $onehot0(grants))
        else begin
          $error("grant is not one-hot at %0t", $time);
          fail_onehot++;
        end
      // Never grant an idle engine
      a_spurious : assert property (@(posedge clock) disable iff (!rstn)
        (grants & ~reqs) == '0)
        else begin
          $error("grant without request at %0t", $time);
          fail_spurious++;
        end
      // Work conserving
      a_missing : assert property (@(posedge clock) disable iff (!rstn)
        (|reqs) |-> (|grants))
        else begin
          $error("requests raised but no grant at %0t", $time);
          fail_missing++;
        end
    end else begin : g_ready
      // Ready and the latched grant come out of reset low
      a_reset : assert property (@(posedge clock)
        $rose(rstn) |-> (ready == '0 && grants == '0))
        else begin
          $error("ready or latched grant not zero after reset at %0t", $time);
          fail_reset++;
        end
    end
  endgenerate

endmodule

bind rr_grant_core arb_asserts #(.N(NUM_REQUESTS), .CORE_VIEW(1'b1)) grant_checks (
  .clock (clock),
  .rstn  (rstn),
  .reqs  (reqs),
  .grants(grants),
  .ready (grants)
);

bind rr_arbiter_1_to_n arb_asserts #(.N(NUM_REQUESTS), .CORE_VIEW(1'b0)) resp_checks (
  .clock (clock),
  .rstn  (rstn),
  .reqs  (requests),
  .grants(grant_latched),
  .ready (ready)
);

/* testbench/tb_top.sv */
/*
  Testbench for the shared command channel
  Directed tests on both arbiters against a reference round-robin model
*/
`timescale 1ns/1ps
`include "arb_defines.svh"

module tb_top;
  import arb_pkg::*;

  localparam int N = `ARB_NUM_PORTS;
  // Run is cut at twice the rough length of all tests in cycles
  localparam int TEST_CYCLES = 70;
  localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;

  logic         clock;
  logic         rstn;
  logic         cmd_enable;
  logic [N-1:0] cmd_req;
  logic [N-1:0] cmd_submit;
  packet_t      cmd_in [0:N-1];
  packet_t      cmd_out;
  logic [N-1:0] cmd_ready;
  logic         resp_enable;
  logic [N-1:0] resp_req;
  packet_t      resp_in;
  packet_t      resp_out [0:N-1];
  logic [N-1:0] resp_ready;

  // Reference model state
  int           cmd_ptr;
  int           resp_ptr;
  logic         cmd_en_int;
  logic [N-1:0] exp_cmd_ready;
  packet_t      exp_cmd_out;
  logic [N-1:0] resp_latched;
  packet_t      exp_resp_out [0:N-1];

  logic [15:0]  lfsr;
  int           error_count = 0;
  int           check_count = 0;
  int           cycle_count = 0;

  cmd_channel_top dut0 (
    .clock      (clock),
    .rstn       (rstn),
    .cmd_enable (cmd_enable),
    .cmd_req    (cmd_req),
    .cmd_submit (cmd_submit),
    .cmd_in     (cmd_in),
    .cmd_out    (cmd_out),
    .cmd_ready  (cmd_ready),
    .resp_enable(resp_enable),
    .resp_req   (resp_req),
    .resp_in    (resp_in),
    .resp_out   (resp_out),
    .resp_ready (resp_ready)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  // Run limit
  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
      $display(">>> FAIL");
      $finish;
    end
  end

  // --------------------------------------------------------------------------
  // Random source and reference model
  // --------------------------------------------------------------------------
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // One LFSR step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r    = {r[30:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
    return r;
  endfunction

  function automatic logic [N-1:0] rand_mask();
    logic [31:0] b;
    b = take_bits(N);
    return b[N-1:0];
  endfunction

  function automatic packet_t rand_packet(input opcode_t op, input int id);
    packet_t     p;
    logic [31:0] b;
    b        = take_bits(`ARB_DATA_WIDTH);
    p.opcode = op;
    p.src    = id[`ARB_SRC_WIDTH-1:0];
    p.data   = b[`ARB_DATA_WIDTH-1:0];
    return p;
  endfunction

  // First raised request at or after the pointer with wraparound
  function automatic logic [N-1:0] rr_pick(input logic [N-1:0] reqs, input int ptr);
    logic [N-1:0] g;
    int           idx;
    g   = '0;
    idx = ptr;
    for (int k = 0; k < N; k++) begin
      if (g == '0 && reqs[idx]) begin
        g[idx] = 1'b1;
      end
      idx = (idx + 1) % N;
    end
    return g;
  endfunction

  function automatic int winner_of(input logic [N-1:0] g);
    int w;
    w = -1;
    for (int i = N - 1; i >= 0; i--) begin
      if (g[i]) begin
        w = i;
      end
    end
    return w;
  endfunction

  // Advance the model by one clock edge using the inputs held over that edge
  task automatic step_model();
    logic [N-1:0] cg;
    logic [N-1:0] rg;
    packet_t      sub;
    int           w;
    cg  = rr_pick(cmd_req, cmd_ptr);
    rg  = rr_pick(resp_req, resp_ptr);
    sub = '0;
    for (int i = 0; i < N; i++) begin
      if (cmd_submit[i]) begin
        sub = cmd_in[i];
      end
    end
    // Command output stage follows the delayed enable
    if (cmd_en_int) begin
      exp_cmd_ready = cg;
      exp_cmd_out   = sub;
    end
    cmd_en_int = cmd_enable;
    w = winner_of(cg);
    if (w >= 0) begin
      cmd_ptr = (w + 1) % N;
    end
    // Response path steers to the engine latched last cycle
    for (int i = 0; i < N; i++) begin
      if (resp_latched[i]) begin
        exp_resp_out[i] = resp_in;
      end else begin
        exp_resp_out[i] = '0;
      end
    end
    if (resp_enable) begin
      resp_latched = rg;
    end
    w = winner_of(rg);
    if (w >= 0) begin
      resp_ptr = (w + 1) % N;
    end
  endtask

  // One cycle that ends on the falling edge where outputs are sampled
  task automatic tick();
    @(posedge clock);
    step_model();
    @(negedge clock);
  endtask

  // --------------------------------------------------------------------------
  // Checking
  // --------------------------------------------------------------------------
  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("CHECK FAILED at %0t: %s, got 0x%0h, expected 0x%0h",
               $time, what, actual, expected);
    end
  endtask

  task automatic check_cmd(input string tag);
    check_value(32'(cmd_ready), 32'(exp_cmd_ready), {tag, " cmd_ready"});
    check_value(32'(cmd_out), 32'(exp_cmd_out), {tag, " cmd_out"});
  endtask

  task automatic check_resp(input string tag);
    for (int i = 0; i < N; i++) begin
      check_value(32'(resp_out[i]), 32'(exp_resp_out[i]),
                  $sformatf("%s resp_out[%0d]", tag, i));
    end
    check_value(32'(resp_ready), 32'(resp_latched & {N{resp_enable}}), {tag, " resp_ready"});
  endtask

  task automatic report_test(input string name, input int errors_before);
    $display("[%0t] test %s finished, %0d errors", $time, name, error_count - errors_before);
  endtask

  // The engine holding ready submits a fresh packet
  task automatic submit_from_ready(output packet_t sent, output bit sent_any);
    sent       = '0;
    sent_any   = 1'b0;
    cmd_submit = '0;
    for (int i = 0; i < N; i++) begin
      if (cmd_ready[i]) begin
        cmd_in[i]     = rand_packet((take_bits(1) == 32'd1) ? op_write : op_read, i);
        cmd_submit[i] = 1'b1;
        sent          = cmd_in[i];
        sent_any      = 1'b1;
      end
    end
  endtask

  // --------------------------------------------------------------------------
  // Directed tests
  // --------------------------------------------------------------------------
  task automatic test_reset_state();
    int e0;
    e0 = error_count;
    check_value(32'(cmd_ready), 32'd0, "cmd_ready after reset");
    check_value(32'(resp_ready), 32'd0, "resp_ready after reset");
    check_value(32'(cmd_out), 32'd0, "cmd_out after reset");
    tick();
    check_cmd("reset idle");
    report_test("reset_state", e0);
  endtask

  task automatic test_round_robin();
    int e0;
    e0 = error_count;
    cmd_enable = 1'b1;
    cmd_req    = '1;
    // Enable registers here
    tick();
    check_cmd("rr enable");
    repeat (5) begin
      tick();
      check_cmd("rr all requests");
    end
    // Random request subsets
    repeat (16) begin
      cmd_req = rand_mask();
      tick();
      check_cmd("rr subset");
    end
    report_test("round_robin", e0);
  endtask

  task automatic test_forwarding();
    packet_t sent;
    bit      sent_any;
    int      e0;
    e0      = error_count;
    cmd_req = '1;
    repeat (8) begin
      submit_from_ready(sent, sent_any);
      tick();
      check_cmd("forward");
      if (sent_any) begin
        check_value(32'(cmd_out), 32'(sent), "cmd_out carries the submitted packet");
      end
    end
    // Nothing submitted
    cmd_submit = '0;
    tick();
    check_cmd("forward idle");
    check_value(32'(cmd_out), 32'd0, "empty cmd_out without submit");
    report_test("forwarding", e0);
  endtask

  task automatic test_enable_hold();
    packet_t      sent;
    bit           sent_any;
    logic [N-1:0] held_ready;
    packet_t      held_out;
    int           e0;
    e0         = error_count;
    cmd_req    = '1;
    cmd_submit = '0;
    tick();
    check_cmd("hold setup");
    // Last enabled edge still captures a packet
    submit_from_ready(sent, sent_any);
    cmd_enable = 1'b0;
    tick();
    check_cmd("hold entry");
    check_value(32'(cmd_out), 32'(sent), "packet captured before hold");
    cmd_submit = '0;
    held_ready = exp_cmd_ready;
    held_out   = exp_cmd_out;
    repeat (4) begin
      cmd_req = rand_mask();
      tick();
      check_cmd("hold");
      check_value(32'(cmd_ready), 32'(held_ready), "cmd_ready frozen");
      check_value(32'(cmd_out), 32'(held_out), "cmd_out frozen");
    end
    // Enable registers while the outputs stay frozen
    cmd_enable = 1'b1;
    cmd_req    = '1;
    tick();
    check_cmd("hold release");
    check_value(32'(cmd_ready), 32'(held_ready), "cmd_ready frozen during enable delay");
    tick();
    check_cmd("hold resumed");
    report_test("enable_hold", e0);
  endtask

  task automatic test_response();
    int e0;
    e0          = error_count;
    resp_enable = 1'b1;
    repeat (16) begin
      resp_req = rand_mask();
      resp_in  = rand_packet(op_resp, int'(take_bits(2)));
      tick();
      check_resp("steer");
    end
    resp_req = '1;
    resp_in  = rand_packet(op_resp, int'(take_bits(2)));
    tick();
    check_resp("steer full");
    // Ready follows the enable without a clock
    resp_enable = 1'b0;
    resp_in     = rand_packet(op_resp, int'(take_bits(2)));
    #1;
    check_value(32'(resp_ready), 32'd0, "resp_ready low with enable low");
    tick();
    check_resp("steer disabled");
    resp_req = rand_mask();
    tick();
    check_resp("steer disabled new requests");
    resp_enable = 1'b1;
    resp_in     = rand_packet(op_resp, int'(take_bits(2)));
    tick();
    check_resp("steer reenabled");
    report_test("response", e0);
  endtask

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------
  function automatic int assertion_failures();
    return dut0.cmd_arb.u_grant.grant_checks.fail_total
         + dut0.resp_arb.u_grant.grant_checks.fail_total
         + dut0.resp_arb.resp_checks.fail_total;
  endfunction

  initial begin
    int total;
    rstn        = 1'b0;
    cmd_enable  = 1'b0;
    cmd_req     = '0;
    cmd_submit  = '0;
    resp_enable = 1'b0;
    resp_req    = '0;
    resp_in     = '0;
    for (int i = 0; i < N; i++) begin
      cmd_in[i]       = '0;
      exp_resp_out[i] = '0;
    end
    lfsr          = 16'd86;
    cmd_ptr       = 0;
    resp_ptr      = 0;
    cmd_en_int    = 1'b0;
    exp_cmd_ready = '0;
    exp_cmd_out   = '0;
    resp_latched  = '0;
    // Two clock edges in reset and release on a falling edge
    repeat (2) @(posedge clock);
    @(negedge clock);
    rstn = 1'b1;

    test_reset_state();
    test_round_robin();
    test_forwarding();
    test_enable_hold();
    test_response();

    total = error_count + assertion_failures();
    $display("Summary: %0d checks, %0d check errors, %0d assertion failures",
             check_count, error_count, assertion_failures());
    if (total == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* src.f */
+incdir+hdl
hdl/arb_pkg.sv
hdl/rr_grant_core.sv
hdl/rr_arbiter_n_to_1.sv
hdl/rr_arbiter_1_to_n.sv
hdl/cmd_channel_top.sv
testbench/tb_asserts.sv
testbench/tb_top.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the command channel testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_top -f src.f -o tb_top_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_top_sim +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q ">>> FAIL" "$LOG"; then
  echo "Simulation reported a failure"
  exit 1
fi

echo "Simulation finished without failures"
exit 0
